// ==== hw/rv_isa_pkg.sv ====
/* RV64 ISA definitions */
`default_nettype none

package rv_isa_pkg;

  // widths fixed by the ISA
  typedef logic [63:0] xlen_t;
  typedef logic [31:0] inst_t;
  typedef logic [4:0]  ridx_t;
  typedef logic [11:0] csr_addr_t;
  typedef logic [4:0]  inst_type_t;
  typedef logic [7:0]  opcode_t;

  localparam inst_type_t TYPE_ALU    = 5'd1;
  localparam inst_type_t TYPE_BRANCH = 5'd2;
  localparam inst_type_t TYPE_JUMP   = 5'd3;
  localparam inst_type_t TYPE_CSR    = 5'd4;
  localparam inst_type_t TYPE_SYSTEM = 5'd5;

  // internal opcodes, assigned by decode
  localparam opcode_t OP_ADD   = 8'h01;
  localparam opcode_t OP_SUB   = 8'h02;
  localparam opcode_t OP_AND   = 8'h03;
  localparam opcode_t OP_OR    = 8'h04;
  localparam opcode_t OP_XOR   = 8'h05;
  localparam opcode_t OP_SLL   = 8'h06;
  localparam opcode_t OP_SRL   = 8'h07;
  localparam opcode_t OP_SLT   = 8'h08;
  localparam opcode_t OP_JAL   = 8'h10;
  localparam opcode_t OP_JALR  = 8'h11;
  localparam opcode_t OP_BEQ   = 8'h12;
  localparam opcode_t OP_BNE   = 8'h13;
  localparam opcode_t OP_CSRRW = 8'h20;
  localparam opcode_t OP_CSRRS = 8'h21;
  localparam opcode_t OP_ECALL = 8'h30;
  localparam opcode_t OP_MRET  = 8'h31;

  // machine CSRs
  localparam csr_addr_t CSR_MSTATUS = 12'h300;
  localparam csr_addr_t CSR_MIE     = 12'h304;
  localparam csr_addr_t CSR_MTVEC   = 12'h305;
  localparam csr_addr_t CSR_MEPC    = 12'h341;
  localparam csr_addr_t CSR_MCAUSE  = 12'h342;
  localparam csr_addr_t CSR_MIP     = 12'h344;

  localparam int MSTATUS_MIE  = 3;
  localparam int MSTATUS_MPIE = 7;
  localparam int MTIE         = 7;
  localparam int MTIP         = 7;

  localparam xlen_t CAUSE_ECALL_M = 64'd11;
  localparam xlen_t CAUSE_MTI     = 64'h8000_0000_0000_0007;

endpackage

`default_nettype wire

// ==== hw/exe_pkg.sv ====
/* Execute stage types */
`default_nettype none

package exe_pkg;
  import rv_isa_pkg::*;

  typedef struct packed {
    inst_type_t inst_type;
    opcode_t    opcode;
    xlen_t      pc;
    inst_t      inst;
    xlen_t      op1;
    xlen_t      op2;
    // branch target
    xlen_t      op3;
    ridx_t      rd;
    logic       rd_wen;
  } decoded_t;

  typedef struct packed {
    xlen_t pc;
    inst_t inst;
    ridx_t rd;
    logic  rd_wen;
    xlen_t rd_wdata;
    logic  pc_jmp;
    xlen_t pc_jmpaddr;
    // 7 for timer interrupt
    xlen_t intr_no;
  } exe_result_t;

  typedef struct packed {
    csr_addr_t addr;
    logic      ren;
    logic      wen;
    xlen_t     wdata;
  } csr_req_t;

  // which trap sequence to run
  typedef logic [1:0] trap_kind_t;

  localparam trap_kind_t KIND_ECALL = 2'd0;
  localparam trap_kind_t KIND_MRET  = 2'd1;
  localparam trap_kind_t KIND_IRQ   = 2'd2;

  typedef enum logic [2:0] {
    TRAP_IDLE,
    TRAP_VEC,
    TRAP_EPC,
    TRAP_CAUSE,
    TRAP_STATUS,
    TRAP_DONE
  } trap_state_t;

endpackage

`default_nettype wire

// ==== hw/exe_unit.sv ====
/* Execute unit */
`timescale 1ns/1ps
`default_nettype none

module exe_unit
  import rv_isa_pkg::*, exe_pkg::*;
(
  input  logic     i_en,
  input  decoded_t i_inst,
  input  xlen_t    i_csr_rdata,
  output csr_req_t o_csr,
  output logic     o_pc_jmp,
  output xlen_t    o_pc_jmpaddr,
  output xlen_t    o_rd_wdata
);

  xlen_t     op1;
  xlen_t     op2;
  logic [5:0] shamt;
  csr_addr_t csr_addr;

  assign op1      = i_inst.op1;
  assign op2      = i_inst.op2;
  assign shamt    = op2[5:0];
  assign csr_addr = i_inst.inst[31:20];

  always_comb begin
    o_csr        = '0;
    o_pc_jmp     = 1'b0;
    o_pc_jmpaddr = '0;
    o_rd_wdata   = '0;
    if (i_en) begin
      case (i_inst.opcode)
        OP_ADD: o_rd_wdata = op1 + op2;
        OP_SUB: o_rd_wdata = op1 - op2;
        OP_AND: o_rd_wdata = op1 & op2;
        OP_OR:  o_rd_wdata = op1 | op2;
        OP_XOR: o_rd_wdata = op1 ^ op2;
        OP_SLL: o_rd_wdata = op1 << shamt;
        OP_SRL: o_rd_wdata = op1 >> shamt;
        OP_SLT: o_rd_wdata = {63'd0, $signed(op1) < $signed(op2)};
        OP_JAL, OP_JALR: begin
          // link address, target comes from decode as op1 + op2
          o_rd_wdata   = i_inst.pc + 64'd4;
          o_pc_jmp     = 1'b1;
          o_pc_jmpaddr = op1 + op2;
        end
        OP_BEQ: begin
          o_pc_jmp     = (op1 == op2);
          o_pc_jmpaddr = i_inst.op3;
        end
        OP_BNE: begin
          o_pc_jmp     = (op1 != op2);
          o_pc_jmpaddr = i_inst.op3;
        end
        OP_CSRRW: begin
          o_csr.addr  = csr_addr;
          o_csr.ren   = 1'b1;
          o_csr.wen   = 1'b1;
          o_csr.wdata = op1;
          o_rd_wdata  = i_csr_rdata;
        end
        OP_CSRRS: begin
          // no write when the set mask is zero
          o_csr.addr  = csr_addr;
          o_csr.ren   = 1'b1;
          o_csr.wen   = |op1;
          o_csr.wdata = i_csr_rdata | op1;
          o_rd_wdata  = i_csr_rdata;
        end
        default: o_rd_wdata = '0;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== hw/trap_unit.sv ====
/* Trap sequencer */
`timescale 1ns/1ps
`default_nettype none

module trap_unit
  import rv_isa_pkg::*, exe_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic       i_en,
  input  trap_kind_t i_kind,
  input  xlen_t      i_pc,
  input  xlen_t      i_csr_rdata,
  output csr_req_t   o_csr,
  output logic       o_done,
  output xlen_t      o_jmpaddr
);

  trap_state_t state;
  trap_state_t state_nxt;
  xlen_t       jmpaddr_q;
  xlen_t       status_wdata;
  logic        is_mret;

  assign is_mret = (i_kind == KIND_MRET);

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= TRAP_IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  // mtvec on entry, mepc on return
  always_ff @(posedge clk) begin
    if (state == TRAP_VEC) begin
      jmpaddr_q <= i_csr_rdata;
    end
  end

  // mstatus read-modify-write
  always_comb begin
    status_wdata = i_csr_rdata;
    if (is_mret) begin
      status_wdata[MSTATUS_MIE]  = i_csr_rdata[MSTATUS_MPIE];
      status_wdata[MSTATUS_MPIE] = 1'b1;
    end else begin
      status_wdata[MSTATUS_MPIE] = i_csr_rdata[MSTATUS_MIE];
      status_wdata[MSTATUS_MIE]  = 1'b0;
    end
  end

  always_comb begin
    state_nxt = state;
    o_csr     = '0;
    case (state)
      TRAP_IDLE: begin
        if (i_en) begin
          state_nxt = TRAP_VEC;
        end
      end
      TRAP_VEC: begin
        o_csr.addr = is_mret ? CSR_MEPC : CSR_MTVEC;
        o_csr.ren  = 1'b1;
        state_nxt  = is_mret ? TRAP_STATUS : TRAP_EPC;
      end
      TRAP_EPC: begin
        o_csr.addr  = CSR_MEPC;
        o_csr.wen   = 1'b1;
        o_csr.wdata = i_pc;
        state_nxt   = TRAP_CAUSE;
      end
      TRAP_CAUSE: begin
        o_csr.addr  = CSR_MCAUSE;
        o_csr.wen   = 1'b1;
        o_csr.wdata = (i_kind == KIND_IRQ) ? CAUSE_MTI : CAUSE_ECALL_M;
        state_nxt   = TRAP_STATUS;
      end
      TRAP_STATUS: begin
        o_csr.addr  = CSR_MSTATUS;
        o_csr.ren   = 1'b1;
        o_csr.wen   = 1'b1;
        o_csr.wdata = status_wdata;
        state_nxt   = TRAP_DONE;
      end
      TRAP_DONE: state_nxt = TRAP_IDLE;
      default:   state_nxt = TRAP_IDLE;
    endcase
  end

  assign o_done    = (state == TRAP_DONE);
  assign o_jmpaddr = jmpaddr_q;

endmodule

`default_nettype wire

// ==== hw/csr_file.sv ====
/* Machine CSR file */
`timescale 1ns/1ps
`default_nettype none

module csr_file
  import rv_isa_pkg::*, exe_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  csr_req_t i_csr,
  input  logic     i_timer_irq,
  output xlen_t    o_rdata,
  output logic     o_irq_pending
);

  xlen_t mstatus;
  xlen_t mie;
  xlen_t mtvec;
  xlen_t mepc;
  xlen_t mcause;
  xlen_t mip;

  // only MTIP exists, driven by the timer
  always_comb begin
    mip       = '0;
    mip[MTIP] = i_timer_irq;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      mstatus <= '0;
      mie     <= '0;
      mtvec   <= '0;
      mepc    <= '0;
      mcause  <= '0;
    end else if (i_csr.wen) begin
      case (i_csr.addr)
        CSR_MSTATUS: mstatus <= i_csr.wdata;
        CSR_MIE:     mie     <= i_csr.wdata;
        CSR_MTVEC:   mtvec   <= i_csr.wdata;
        CSR_MEPC:    mepc    <= i_csr.wdata;
        CSR_MCAUSE:  mcause  <= i_csr.wdata;
        default:     mepc    <= mepc;
      endcase
    end
  end

  always_comb begin
    o_rdata = '0;
    if (i_csr.ren) begin
      case (i_csr.addr)
        CSR_MSTATUS: o_rdata = mstatus;
        CSR_MIE:     o_rdata = mie;
        CSR_MTVEC:   o_rdata = mtvec;
        CSR_MEPC:    o_rdata = mepc;
        CSR_MCAUSE:  o_rdata = mcause;
        CSR_MIP:     o_rdata = mip;
        default:     o_rdata = '0;
      endcase
    end
  end

  assign o_irq_pending = mstatus[MSTATUS_MIE] & mie[MTIE] & mip[MTIP];

endmodule

`default_nettype wire

// ==== hw/exe_stage.sv ====
/* Execute stage control */
`timescale 1ns/1ps
`default_nettype none

module exe_stage
  import rv_isa_pkg::*, exe_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  logic        i_decoded_req,
  input  decoded_t    i_decoded,
  input  logic        i_executed_ack,
  input  logic        i_irq_pending,
  input  csr_req_t    i_exu_csr,
  input  logic        i_exu_jmp,
  input  xlen_t       i_exu_jmpaddr,
  input  xlen_t       i_exu_rd_wdata,
  input  logic        i_trap_done,
  input  xlen_t       i_trap_jmpaddr,
  input  csr_req_t    i_trap_csr,
  output logic        o_decoded_ack,
  output logic        o_executed_req,
  output exe_result_t o_result,
  output decoded_t    o_inst,
  output logic        o_exu_en,
  output logic        o_trap_en,
  output trap_kind_t  o_trap_kind,
  output csr_req_t    o_csr
);

  logic       busy;
  logic       req_q;
  logic       exu_en_q;
  logic       trap_en_q;
  logic       irq_q;
  trap_kind_t kind_q;
  decoded_t   inst_q;
  logic       decoded_hs;
  logic       executed_hs;
  csr_req_t   exu_csr_gated;

  assign o_decoded_ack = ~busy;
  assign decoded_hs    = i_decoded_req & o_decoded_ack;
  assign executed_hs   = req_q & i_executed_ack;

  always_ff @(posedge clk) begin
    if (rst) begin
      busy      <= 1'b0;
      req_q     <= 1'b0;
      exu_en_q  <= 1'b0;
      trap_en_q <= 1'b0;
      irq_q     <= 1'b0;
      kind_q    <= KIND_ECALL;
    end else if (decoded_hs) begin
      busy <= 1'b1;
      // unit is chosen once, here
      if (i_irq_pending) begin
        trap_en_q <= 1'b1;
        irq_q     <= 1'b1;
        kind_q    <= KIND_IRQ;
      end else if (i_decoded.opcode == OP_ECALL) begin
        trap_en_q <= 1'b1;
        kind_q    <= KIND_ECALL;
      end else if (i_decoded.opcode == OP_MRET) begin
        trap_en_q <= 1'b1;
        kind_q    <= KIND_MRET;
      end else begin
        // execute unit finishes at once
        exu_en_q <= 1'b1;
        req_q    <= 1'b1;
      end
    end else if (executed_hs) begin
      busy     <= 1'b0;
      req_q    <= 1'b0;
      exu_en_q <= 1'b0;
      irq_q    <= 1'b0;
    end else if (i_trap_done) begin
      trap_en_q <= 1'b0;
      req_q     <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (decoded_hs) begin
      inst_q <= i_decoded;
    end
  end

  // csr instruction writes only on the handshake edge
  always_comb begin
    exu_csr_gated     = i_exu_csr;
    exu_csr_gated.wen = i_exu_csr.wen & executed_hs;
  end

  assign o_csr = exu_en_q ? exu_csr_gated : i_trap_csr;

  always_comb begin
    o_result.pc         = inst_q.pc;
    o_result.inst       = inst_q.inst;
    o_result.rd         = inst_q.rd;
    o_result.rd_wen     = exu_en_q & inst_q.rd_wen;
    o_result.rd_wdata   = exu_en_q ? i_exu_rd_wdata : '0;
    o_result.pc_jmp     = exu_en_q ? i_exu_jmp : 1'b1;
    o_result.pc_jmpaddr = exu_en_q ? i_exu_jmpaddr : i_trap_jmpaddr;
    o_result.intr_no    = irq_q ? 64'd7 : 64'd0;
  end

  assign o_executed_req = req_q;
  assign o_inst         = inst_q;
  assign o_exu_en       = exu_en_q;
  assign o_trap_en      = trap_en_q;
  assign o_trap_kind    = kind_q;

endmodule

`default_nettype wire

// ==== hw/exe_top.sv ====
/* Execute subsystem top */
`timescale 1ns/1ps
`default_nettype none

module exe_top
  import rv_isa_pkg::*, exe_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  logic        i_decoded_req,
  input  decoded_t    i_decoded,
  input  logic        i_executed_ack,
  input  logic        i_timer_irq,
  output logic        o_decoded_ack,
  output logic        o_executed_req,
  output exe_result_t o_result
);

  decoded_t   inst;
  logic       exu_en;
  logic       trap_en;
  trap_kind_t trap_kind;
  csr_req_t   exu_csr;
  csr_req_t   trap_csr;
  csr_req_t   csr;
  logic       exu_jmp;
  xlen_t      exu_jmpaddr;
  xlen_t      exu_rd_wdata;
  logic       trap_done;
  xlen_t      trap_jmpaddr;
  xlen_t      csr_rdata;
  logic       irq_pending;

  exe_stage u_stage (
    .clk            (clk),
    .rst            (rst),
    .i_decoded_req  (i_decoded_req),
    .i_decoded      (i_decoded),
    .i_executed_ack (i_executed_ack),
    .i_irq_pending  (irq_pending),
    .i_exu_csr      (exu_csr),
    .i_exu_jmp      (exu_jmp),
    .i_exu_jmpaddr  (exu_jmpaddr),
    .i_exu_rd_wdata (exu_rd_wdata),
    .i_trap_done    (trap_done),
    .i_trap_jmpaddr (trap_jmpaddr),
    .i_trap_csr     (trap_csr),
    .o_decoded_ack  (o_decoded_ack),
    .o_executed_req (o_executed_req),
    .o_result       (o_result),
    .o_inst         (inst),
    .o_exu_en       (exu_en),
    .o_trap_en      (trap_en),
    .o_trap_kind    (trap_kind),
    .o_csr          (csr)
  );

  exe_unit u_exu (
    .i_en         (exu_en),
    .i_inst       (inst),
    .i_csr_rdata  (csr_rdata),
    .o_csr        (exu_csr),
    .o_pc_jmp     (exu_jmp),
    .o_pc_jmpaddr (exu_jmpaddr),
    .o_rd_wdata   (exu_rd_wdata)
  );

  trap_unit u_trap (
    .clk         (clk),
    .rst         (rst),
    .i_en        (trap_en),
    .i_kind      (trap_kind),
    .i_pc        (inst.pc),
    .i_csr_rdata (csr_rdata),
    .o_csr       (trap_csr),
    .o_done      (trap_done),
    .o_jmpaddr   (trap_jmpaddr)
  );

  csr_file u_csr (
    .clk           (clk),
    .rst           (rst),
    .i_csr         (csr),
    .i_timer_irq   (i_timer_irq),
    .o_rdata       (csr_rdata),
    .o_irq_pending (irq_pending)
  );

endmodule

`default_nettype wire

// ==== tests/tb_exe_top.sv ====
/* Execute stage testbench */
`timescale 1ns/1ps
`default_nettype none

module tb_exe_top
  import rv_isa_pkg::*, exe_pkg::*;
();

  typedef struct packed {
    decoded_t   dec;
    logic       irq;
    logic [3:0] ack_delay;
    logic       rd_wen;
    logic       wdata_valid;
    xlen_t      rd_wdata;
    logic       pc_jmp;
    xlen_t      pc_jmpaddr;
    xlen_t      intr_no;
  } entry_t;

  logic        clk = 1'b0;
  logic        rst;
  logic        i_decoded_req;
  decoded_t    i_decoded;
  logic        i_executed_ack;
  logic        i_timer_irq;
  logic        o_decoded_ack;
  logic        o_executed_req;
  exe_result_t o_result;

  entry_t      tbl[$];
  int          cycles;
  int          max_cycles;

  // reference copy of the machine CSRs
  xlen_t m_mstatus;
  xlen_t m_mie;
  xlen_t m_mtvec;
  xlen_t m_mepc;
  xlen_t m_mcause;

  exe_top UUT (
    .clk            (clk),
    .rst            (rst),
    .i_decoded_req  (i_decoded_req),
    .i_decoded      (i_decoded),
    .i_executed_ack (i_executed_ack),
    .i_timer_irq    (i_timer_irq),
    .o_decoded_ack  (o_decoded_ack),
    .o_executed_req (o_executed_req),
    .o_result       (o_result)
  );

  always #5 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles > max_cycles) begin
      $display("timeout: the DUT did not finish the table within %0d cycles", max_cycles);
      abort_run();
    end
  end

  task automatic abort_run();
    $display("Result: FAILED");
    $fatal(1, "simulation stopped on the first error");
  endtask

  task automatic check_xlen(input string name, input xlen_t got, input xlen_t exp);
    if (got !== exp) begin
      $display("Fail at %0t: %s is %h, expected %h", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Fail at %0t: %s is %b, expected %b", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_ridx(input string name, input ridx_t got, input ridx_t exp);
    if (got !== exp) begin
      $display("Fail at %0t: %s is %0d, expected %0d", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_inst(input string name, input inst_t got, input inst_t exp);
    if (got !== exp) begin
      $display("Fail at %0t: %s is %h, expected %h", $time, name, got, exp);
      abort_run();
    end
  endtask

  function automatic xlen_t alu_model(input opcode_t op, input xlen_t a, input xlen_t b);
    case (op)
      OP_ADD:  return a + b;
      OP_SUB:  return a - b;
      OP_AND:  return a & b;
      OP_OR:   return a | b;
      OP_XOR:  return a ^ b;
      OP_SLL:  return a << b[5:0];
      OP_SRL:  return a >> b[5:0];
      OP_SLT:  return ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
      default: return '0;
    endcase
  endfunction

  function automatic xlen_t read_csr_model(input csr_addr_t addr, input logic irq);
    case (addr)
      CSR_MSTATUS: return m_mstatus;
      CSR_MIE:     return m_mie;
      CSR_MTVEC:   return m_mtvec;
      CSR_MEPC:    return m_mepc;
      CSR_MCAUSE:  return m_mcause;
      CSR_MIP:     return {56'd0, irq, 7'd0};
      default:     return '0;
    endcase
  endfunction

  task automatic store_csr_model(input csr_addr_t addr, input xlen_t val);
    case (addr)
      CSR_MSTATUS: m_mstatus = val;
      CSR_MIE:     m_mie = val;
      CSR_MTVEC:   m_mtvec = val;
      CSR_MEPC:    m_mepc = val;
      CSR_MCAUSE:  m_mcause = val;
      default:     m_mepc = m_mepc;
    endcase
  endtask

  task automatic take_trap(input xlen_t pc, input xlen_t cause);
    m_mepc = pc;
    m_mcause = cause;
    m_mstatus[MSTATUS_MPIE] = m_mstatus[MSTATUS_MIE];
    m_mstatus[MSTATUS_MIE] = 1'b0;
  endtask

  // works out the expected result and updates the reference CSRs
  task automatic add_entry(input decoded_t d, input logic irq, input int delay);
    entry_t    e;
    csr_addr_t addr;
    xlen_t     old;
    e = '0;
    e.dec = d;
    e.irq = irq;
    e.ack_delay = delay[3:0];
    addr = d.inst[31:20];
    old = read_csr_model(addr, irq);
    if (m_mstatus[MSTATUS_MIE] && m_mie[MTIE] && irq) begin
      e.pc_jmp = 1'b1;
      e.pc_jmpaddr = m_mtvec;
      e.intr_no = 64'd7;
      take_trap(d.pc, CAUSE_MTI);
    end else begin
      case (d.opcode)
        OP_JAL, OP_JALR: begin
          e.rd_wen = d.rd_wen;
          e.wdata_valid = 1'b1;
          e.rd_wdata = d.pc + 64'd4;
          e.pc_jmp = 1'b1;
          e.pc_jmpaddr = d.op1 + d.op2;
        end
        OP_BEQ, OP_BNE: begin
          e.rd_wen = d.rd_wen;
          e.pc_jmp = (d.opcode == OP_BEQ) ? (d.op1 == d.op2) : (d.op1 != d.op2);
          e.pc_jmpaddr = d.op3;
        end
        OP_CSRRW, OP_CSRRS: begin
          e.rd_wen = d.rd_wen;
          e.wdata_valid = 1'b1;
          e.rd_wdata = old;
          if (d.opcode == OP_CSRRW) begin
            store_csr_model(addr, d.op1);
          end else if (d.op1 != '0) begin
            store_csr_model(addr, old | d.op1);
          end
        end
        OP_ECALL: begin
          e.pc_jmp = 1'b1;
          e.pc_jmpaddr = m_mtvec;
          take_trap(d.pc, CAUSE_ECALL_M);
        end
        OP_MRET: begin
          e.pc_jmp = 1'b1;
          e.pc_jmpaddr = m_mepc;
          m_mstatus[MSTATUS_MIE] = m_mstatus[MSTATUS_MPIE];
          m_mstatus[MSTATUS_MPIE] = 1'b1;
        end
        default: begin
          e.rd_wen = d.rd_wen;
          e.wdata_valid = 1'b1;
          e.rd_wdata = alu_model(d.opcode, d.op1, d.op2);
        end
      endcase
    end
    tbl.push_back(e);
  endtask

  function automatic decoded_t alu_inst(input opcode_t op, input xlen_t pc, input xlen_t a,
                                        input xlen_t b, input ridx_t rd, input logic wen);
    decoded_t d;
    d = '0;
    d.inst_type = TYPE_ALU;
    d.opcode = op;
    d.pc = pc;
    d.inst = 32'h0000_0033;
    d.op1 = a;
    d.op2 = b;
    d.rd = rd;
    d.rd_wen = wen;
    return d;
  endfunction

  function automatic decoded_t jump_inst(input opcode_t op, input xlen_t pc, input xlen_t a,
                                         input xlen_t b, input ridx_t rd);
    decoded_t d;
    d = alu_inst(op, pc, a, b, rd, 1'b1);
    d.inst_type = TYPE_JUMP;
    d.inst = 32'h0000_006f;
    return d;
  endfunction

  function automatic decoded_t branch_inst(input opcode_t op, input xlen_t pc, input xlen_t a,
                                           input xlen_t b, input xlen_t target);
    decoded_t d;
    d = alu_inst(op, pc, a, b, 5'd0, 1'b0);
    d.inst_type = TYPE_BRANCH;
    d.inst = 32'h0000_0063;
    d.op3 = target;
    return d;
  endfunction

  function automatic decoded_t csr_inst(input opcode_t op, input xlen_t pc,
                                        input csr_addr_t addr, input xlen_t val, input ridx_t rd);
    decoded_t d;
    d = alu_inst(op, pc, val, 64'd0, rd, 1'b1);
    d.inst_type = TYPE_CSR;
    d.inst = {addr, 20'h0_1073};
    return d;
  endfunction

  function automatic decoded_t sys_inst(input opcode_t op, input xlen_t pc);
    decoded_t d;
    d = alu_inst(op, pc, 64'd0, 64'd0, 5'd0, 1'b0);
    d.inst_type = TYPE_SYSTEM;
    d.inst = 32'h0000_0073;
    return d;
  endfunction

  task automatic fill_table();
    opcode_t alu_ops [8];
    xlen_t   pc;
    int      i;
    alu_ops = '{OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLL, OP_SRL, OP_SLT};
    pc = 64'h0000_1000;
    // random operands, a few without a register write
    for (i = 0; i < 16; i++) begin
      add_entry(alu_inst(alu_ops[i % 8], pc, {$urandom, $urandom}, {$urandom, $urandom},
                         ridx_t'(i + 1), (i % 5) != 4), 1'b0, i % 3);
      pc = pc + 64'd4;
    end
    add_entry(jump_inst(OP_JAL, 64'h2000, 64'h2000, 64'h124, 5'd1), 1'b0, 0);
    add_entry(jump_inst(OP_JALR, 64'h2004, 64'h8000_0000, 64'hffff_ffff_ffff_fff8, 5'd5),
              1'b0, 1);
    add_entry(branch_inst(OP_BEQ, 64'h2008, 64'd77, 64'd77, 64'h2100), 1'b0, 0);
    add_entry(branch_inst(OP_BEQ, 64'h200c, 64'd77, 64'd78, 64'h2200), 1'b0, 0);
    add_entry(branch_inst(OP_BNE, 64'h2010, 64'd5, 64'd6, 64'h2300), 1'b0, 0);
    add_entry(branch_inst(OP_BNE, 64'h2014, 64'd6, 64'd6, 64'h2400), 1'b0, 0);
    add_entry(csr_inst(OP_CSRRW, 64'h3000, CSR_MTVEC, 64'h8000_0100, 5'd10), 1'b0, 0);
    add_entry(csr_inst(OP_CSRRS, 64'h3004, CSR_MTVEC, 64'd0, 5'd11), 1'b0, 0);
    // ecall, its saved state, then return
    add_entry(sys_inst(OP_ECALL, 64'h4444), 1'b0, 1);
    add_entry(csr_inst(OP_CSRRS, 64'h8000_0100, CSR_MEPC, 64'd0, 5'd12), 1'b0, 0);
    add_entry(csr_inst(OP_CSRRS, 64'h8000_0104, CSR_MCAUSE, 64'd0, 5'd12), 1'b0, 0);
    add_entry(sys_inst(OP_MRET, 64'h8000_0108), 1'b0, 2);
    // enable the timer interrupt, then raise it
    add_entry(csr_inst(OP_CSRRW, 64'h4448, CSR_MIE, 64'h80, 5'd13), 1'b0, 0);
    add_entry(csr_inst(OP_CSRRS, 64'h444c, CSR_MSTATUS, 64'h8, 5'd14), 1'b0, 0);
    add_entry(alu_inst(OP_ADD, 64'h5000, 64'd1, 64'd2, 5'd15, 1'b1), 1'b1, 0);
    add_entry(csr_inst(OP_CSRRS, 64'h8000_0100, CSR_MCAUSE, 64'd0, 5'd16), 1'b0, 0);
    add_entry(csr_inst(OP_CSRRS, 64'h8000_0104, CSR_MEPC, 64'd0, 5'd16), 1'b0, 0);
    // results held back by a late ack
    add_entry(csr_inst(OP_CSRRW, 64'h6000, CSR_MEPC, 64'h1234, 5'd17), 1'b0, 4);
    add_entry(csr_inst(OP_CSRRS, 64'h6004, CSR_MEPC, 64'd0, 5'd18), 1'b0, 0);
    add_entry(csr_inst(OP_CSRRS, 64'h6008, CSR_MTVEC, 64'h4, 5'd19), 1'b0, 3);
    add_entry(csr_inst(OP_CSRRS, 64'h600c, CSR_MTVEC, 64'd0, 5'd20), 1'b0, 0);
  endtask

  task automatic apply_entry(input entry_t e);
    exe_result_t held;
    int          k;
    @(negedge clk);
    if (o_decoded_ack !== 1'b1) begin
      $display("the DUT is not ready for a new instruction at %0t", $time);
      abort_run();
    end
    @(posedge clk);
    i_decoded_req <= 1'b1;
    i_decoded     <= e.dec;
    i_timer_irq   <= e.irq;
    @(posedge clk);
    i_decoded_req <= 1'b0;
    // trap sequences need several cycles
    @(negedge clk);
    while (o_executed_req !== 1'b1) begin
      @(negedge clk);
    end
    check_bit("o_decoded_ack", o_decoded_ack, 1'b0);
    check_xlen("o_result.pc", o_result.pc, e.dec.pc);
    check_inst("o_result.inst", o_result.inst, e.dec.inst);
    check_ridx("o_result.rd", o_result.rd, e.dec.rd);
    check_bit("o_result.rd_wen", o_result.rd_wen, e.rd_wen);
    if (e.wdata_valid) begin
      check_xlen("o_result.rd_wdata", o_result.rd_wdata, e.rd_wdata);
    end
    check_bit("o_result.pc_jmp", o_result.pc_jmp, e.pc_jmp);
    if (e.pc_jmp) begin
      check_xlen("o_result.pc_jmpaddr", o_result.pc_jmpaddr, e.pc_jmpaddr);
    end
    check_xlen("o_result.intr_no", o_result.intr_no, e.intr_no);
    held = o_result;
    for (k = 0; k < int'(e.ack_delay); k++) begin
      @(negedge clk);
      check_bit("o_executed_req", o_executed_req, 1'b1);
      check_bit("o_decoded_ack", o_decoded_ack, 1'b0);
      check_bit("o_result.rd_wen", o_result.rd_wen, held.rd_wen);
      check_xlen("o_result.rd_wdata", o_result.rd_wdata, held.rd_wdata);
      check_bit("o_result.pc_jmp", o_result.pc_jmp, held.pc_jmp);
      check_xlen("o_result.pc_jmpaddr", o_result.pc_jmpaddr, held.pc_jmpaddr);
      check_xlen("o_result.intr_no", o_result.intr_no, held.intr_no);
    end
    @(posedge clk);
    i_executed_ack <= 1'b1;
    @(posedge clk);
    i_executed_ack <= 1'b0;
  endtask

  initial begin
    rst            = 1'b1;
    i_decoded_req  = 1'b0;
    i_decoded      = '0;
    i_executed_ack = 1'b0;
    i_timer_irq    = 1'b0;
    cycles         = 0;
    m_mstatus      = '0;
    m_mie          = '0;
    m_mtvec        = '0;
    m_mepc         = '0;
    m_mcause       = '0;
    void'($urandom(40));
    fill_table();
    max_cycles = tbl.size() * 20;
    repeat (4) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    check_bit("o_executed_req", o_executed_req, 1'b0);
    check_bit("o_decoded_ack", o_decoded_ack, 1'b1);
    foreach (tbl[n]) begin
      apply_entry(tbl[n]);
    end
    $display("Result: PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== src.f ====
hw/rv_isa_pkg.sv
hw/exe_pkg.sv
hw/exe_unit.sv
hw/trap_unit.sv
hw/csr_file.sv
hw/exe_stage.sv
hw/exe_top.sv
tests/tb_exe_top.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       := tb_exe_top
FILELIST  := src.f
VFLAGS    := --binary --timing -Wno-fatal --top-module $(TOP)
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SRCS      := $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "Result: PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
